// ==== rtl/alu_pkg.sv ====
// Shared widths, opcodes and bus/record structs for the execute stage; import with alu_pkg::*
package alu_pkg;

    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 8;
    localparam int NUM_REGS  = 4;
    localparam int REG_IDX_W = $clog2(NUM_REGS);
    localparam int MEM_DEPTH = 1 << ADDR_W;   // One byte per address

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_ADC  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_LAND = 4'd5,
        OP_LOR  = 4'd6,
        OP_LNOT = 4'd7,
        OP_SHL  = 4'd8,
        OP_CMP  = 4'd9,
        OP_LDI  = 4'd10,
        OP_LD   = 4'd11,
        OP_ST   = 4'd12
    } opcode_e;

    typedef struct packed {
        opcode_e              opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs;
        logic [DATA_W-1:0]    imm;    // Immediate or memory address
    } instr_t;

    typedef enum logic [1:0] {
        LG_LAND = 2'd0,
        LG_BAND = 2'd1,
        LG_LOR  = 2'd2,
        LG_BOR  = 2'd3
    } lgcl_e;

    typedef struct packed {
        logic  add_op;          // Adder drives the result
        logic  carry_in;
        logic  en_complement;   // Invert operand 2
        lgcl_e lgcl_sel;
        logic  lgcl_en;         // Logical unit drives the result
        logic  compare_true;    // Enables gt/lt/eq
        logic  store_true;      // Operand 2 forced to zero
    } alu_ctrl_t;

    typedef struct packed {
        logic cout;
        logic gt;
        logic lt;
        logic eq;
    } alu_flags_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                 valid;
        opcode_e              opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [DATA_W-1:0]    value;
        alu_flags_t           flags;
    } retire_t;

endpackage

// ==== rtl/pl_alu.sv ====
// Combinational 8-bit ALU used by the execute stage; operands and control in, result and flags out
`timescale 1ns/1ps

module pl_alu
    import alu_pkg::*;
(
    input  logic [DATA_W-1:0] op1_in,
    input  logic [DATA_W-1:0] op2_in,
    input  alu_ctrl_t         ctrl,
    output logic [DATA_W-1:0] result,
    output alu_flags_t        flags
);

    logic [DATA_W-1:0] op2;
    logic [DATA_W-1:0] add_res;
    logic [DATA_W-1:0] shl_res;
    logic [DATA_W-1:0] lgcl_res;
    logic              add_cout;
    logic              shl_cout;
    logic              op1_nz;
    logic              op2_nz;

    // Zeroing happens first so a zeroed operand can still be inverted
    assign op2 = (ctrl.store_true ? '0 : op2_in) ^ {DATA_W{ctrl.en_complement}};

    // Adder with carry, also the subtractor and comparator
    assign {add_cout, add_res} = {1'b0, op1_in} + {1'b0, op2}
                               + {{DATA_W{1'b0}}, ctrl.carry_in};

    // Left shift by one, MSB goes out as carry
    assign shl_res  = {op1_in[DATA_W-2:0], 1'b0};
    assign shl_cout = op1_in[DATA_W-1];

    assign op1_nz = |op1_in;
    assign op2_nz = |op2;

    always_comb
    begin
        case (ctrl.lgcl_sel)
            LG_LAND: lgcl_res = {{(DATA_W-1){1'b0}}, op1_nz && op2_nz};   // 0 or 1
            LG_BAND: lgcl_res = op1_in & op2;
            LG_LOR:  lgcl_res = {{(DATA_W-1){1'b0}}, op1_nz || op2_nz};
            LG_BOR:  lgcl_res = op1_in | op2;
            default: lgcl_res = '0;
        endcase
    end

    // Result select, shifter when neither adder nor logic unit is enabled
    always_comb
    begin
        if (ctrl.add_op)
        begin
            result     = add_res;
            flags.cout = add_cout;
        end
        else if (ctrl.lgcl_en)
        begin
            result     = lgcl_res;
            flags.cout = 1'b0;   // Logic ops never carry
        end
        else
        begin
            result     = shl_res;
            flags.cout = shl_cout;
        end
    end

    // Carry set on op1 - op2 means no borrow, so op1 >= op2
    assign flags.eq = ctrl.compare_true && (add_res == '0);
    assign flags.gt = ctrl.compare_true && add_cout && (add_res != '0);
    assign flags.lt = ctrl.compare_true && !add_cout && (add_res != '0);

endmodule

// ==== rtl/ex_stage.sv ====
// Execute stage: decodes instructions, holds the register file, retires results, issues LD/ST on Wishbone
`timescale 1ns/1ps

module ex_stage
    import alu_pkg::*;
(
    input  logic    shift_en,
    input  logic    reset,
    input  instr_t  instr,
    input  logic    instr_valid,
    output logic    instr_ready,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    output retire_t retire
);

    typedef enum logic [1:0] {IDLE, BUS, DONE} state_e;

    state_e            state;
    instr_t            cur;                // Instruction in the execute slot
    logic              cur_valid;
    logic              cur_mem;
    logic              carry;              // Carry of the last ALU op, feeds ADC
    logic [DATA_W-1:0] regs [NUM_REGS];
    alu_ctrl_t         ctrl;
    logic [DATA_W-1:0] alu_op1;
    logic [DATA_W-1:0] alu_result;
    alu_flags_t        alu_flags;
    logic [DATA_W-1:0] exe_value;
    alu_flags_t        exe_flags;
    logic              exe_wr;

    assign cur_mem = (cur.opcode == OP_LD) || (cur.opcode == OP_ST);

    always_comb
    begin
        ctrl = '0;   // LDI, LD and SHL leave everything low
        case (cur.opcode)
            OP_ADD:  ctrl.add_op = 1'b1;
            OP_ADC:
            begin
                ctrl.add_op   = 1'b1;
                ctrl.carry_in = carry;
            end
            OP_SUB, OP_CMP:
            begin
                ctrl.add_op        = 1'b1;
                ctrl.en_complement = 1'b1;
                ctrl.carry_in      = 1'b1;   // Two's complement
                ctrl.compare_true  = (cur.opcode == OP_CMP);
            end
            OP_AND:  {ctrl.lgcl_en, ctrl.lgcl_sel} = {1'b1, LG_BAND};
            OP_OR:   {ctrl.lgcl_en, ctrl.lgcl_sel} = {1'b1, LG_BOR};
            OP_LAND: {ctrl.lgcl_en, ctrl.lgcl_sel} = {1'b1, LG_LAND};
            OP_LOR:  {ctrl.lgcl_en, ctrl.lgcl_sel} = {1'b1, LG_LOR};
            OP_LNOT:
            begin
                // rd && ~0 gives rd != 0, inverted below
                {ctrl.lgcl_en, ctrl.lgcl_sel} = {1'b1, LG_LAND};
                ctrl.store_true    = 1'b1;
                ctrl.en_complement = 1'b1;
            end
            OP_ST:
            begin
                ctrl.add_op     = 1'b1;   // Pass rs through the adder
                ctrl.store_true = 1'b1;
            end
            default: ;
        endcase
    end

    assign alu_op1 = (cur.opcode == OP_ST) ? regs[cur.rs] : regs[cur.rd];

    pl_alu u_alu (
        .op1_in (alu_op1),
        .op2_in (regs[cur.rs]),
        .ctrl   (ctrl),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_comb
    begin
        exe_value = alu_result;
        exe_flags = alu_flags;
        exe_wr    = 1'b1;
        case (cur.opcode)
            OP_LDI:
            begin
                exe_value = cur.imm;
                exe_flags = '0;
            end
            OP_LNOT: exe_value = {{(DATA_W-1){1'b0}}, ~alu_result[0]};
            OP_CMP:  exe_wr = 1'b0;   // Flags only, rd untouched
            default: ;
        endcase
    end

    assign instr_ready = (state != BUS) && !(cur_valid && cur_mem);

    always_comb
    begin
        wb_req.cyc = (state == BUS);
        wb_req.stb = (state == BUS);
        wb_req.we  = (cur.opcode == OP_ST);
        wb_req.adr = cur.imm;
        wb_req.dat = alu_result;   // rs value via store pass-through
    end

    always_ff @(posedge shift_en)
    begin
        if (reset)
        begin
            state        <= IDLE;
            cur_valid    <= 1'b0;
            carry        <= 1'b0;
            retire.valid <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            retire.valid <= 1'b0;
            case (state)
                IDLE, DONE:
                begin
                    state <= IDLE;
                    if (cur_valid && cur_mem)
                    begin
                        state <= BUS;   // Bus cycle opens one edge after acceptance
                    end
                    else if (cur_valid)
                    begin
                        cur_valid <= 1'b0;
                        retire    <= '{valid: 1'b1, opcode: cur.opcode, rd: cur.rd,
                                       value: exe_value, flags: exe_flags};
                        if (exe_wr)
                        begin
                            regs[cur.rd] <= exe_value;
                        end
                        if (cur.opcode != OP_LDI)
                        begin
                            carry <= alu_flags.cout;
                        end
                    end
                    if (instr_valid && instr_ready)
                    begin
                        cur       <= instr;
                        cur_valid <= 1'b1;
                    end
                end
                BUS:
                begin
                    if (wb_rsp.ack)
                    begin
                        state     <= DONE;
                        cur_valid <= 1'b0;
                        retire    <= '{valid: 1'b1, opcode: cur.opcode, rd: cur.rd,
                                       value: wb_req.we ? alu_result : wb_rsp.dat,
                                       flags: '0};
                        if (!wb_req.we)
                        begin
                            regs[cur.rd] <= wb_rsp.dat;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/wb_arbiter.sv ====
// Round-robin arbiter sharing one Wishbone classic slave between two masters
`timescale 1ns/1ps

module wb_arbiter
    import alu_pkg::*;
(
    input  logic    shift_en,
    input  logic    reset,
    input  wb_req_t m0_req,
    output wb_rsp_t m0_rsp,
    input  wb_req_t m1_req,
    output wb_rsp_t m1_rsp,
    output wb_req_t s_req,
    input  wb_rsp_t s_rsp
);

    logic [1:0] grant;      // One-hot, bit 1 is master 1
    logic       last_m1;    // Master 1 won the last arbitration
    logic       owner_cyc;

    // Grant may only move once its owner has closed the cycle
    assign owner_cyc = (grant[0] && m0_req.cyc) || (grant[1] && m1_req.cyc);

    always_ff @(posedge shift_en)
    begin
        if (reset)
        begin
            grant   <= 2'b00;
            last_m1 <= 1'b1;   // Master 0 first on a tie
        end
        else if (!owner_cyc)
        begin
            if (m0_req.cyc && m1_req.cyc)
            begin
                grant   <= last_m1 ? 2'b01 : 2'b10;
                last_m1 <= !last_m1;
            end
            else if (m0_req.cyc)
            begin
                grant   <= 2'b01;
                last_m1 <= 1'b0;
            end
            else if (m1_req.cyc)
            begin
                grant   <= 2'b10;
                last_m1 <= 1'b1;
            end
            else
            begin
                grant <= 2'b00;
            end
        end
    end

    // Slave sees nothing until a grant is held
    assign s_req = grant[1] ? m1_req :
                   grant[0] ? m0_req : '0;

    assign m0_rsp = grant[0] ? s_rsp : '0;
    assign m1_rsp = grant[1] ? s_rsp : '0;

endmodule

// ==== rtl/data_mem.sv ====
// 256-byte Wishbone classic slave memory with one-cycle registered ack
`timescale 1ns/1ps

module data_mem
    import alu_pkg::*;
(
    input  logic    shift_en,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              access;

    // New access only while ack is low, so each stb gets a single ack
    assign access = wb_req.cyc && wb_req.stb && !ack;

    always_ff @(posedge shift_en)
    begin
        if (reset)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= access;
        end
    end

    always_ff @(posedge shift_en)
    begin
        if (access && wb_req.we)
        begin
            mem[wb_req.adr] <= wb_req.dat;
        end
        if (access)
        begin
            rdata <= mem[wb_req.adr];   // Read data lands with ack
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rdata;

endmodule

// ==== rtl/alu_ex_top.sv ====
// Top level: execute stage and host port sharing the data memory through the arbiter
`timescale 1ns/1ps

module alu_ex_top
    import alu_pkg::*;
(
    input  logic    shift_en,
    input  logic    reset,
    input  instr_t  instr,
    input  logic    instr_valid,
    output logic    instr_ready,
    input  wb_req_t host_req,
    output wb_rsp_t host_rsp,
    output retire_t retire
);

    wb_req_t ex_req;
    wb_rsp_t ex_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    ex_stage u_ex (
        .shift_en    (shift_en),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .wb_req      (ex_req),
        .wb_rsp      (ex_rsp),
        .retire      (retire)
    );

    // Master 0 is the execute stage, master 1 the host port
    wb_arbiter u_arb (
        .shift_en (shift_en),
        .reset    (reset),
        .m0_req   (ex_req),
        .m0_rsp   (ex_rsp),
        .m1_req   (host_req),
        .m1_rsp   (host_rsp),
        .s_req    (mem_req),
        .s_rsp    (mem_rsp)
    );

    data_mem u_mem (
        .shift_en (shift_en),
        .reset    (reset),
        .wb_req   (mem_req),
        .wb_rsp   (mem_rsp)
    );

endmodule

// ==== verification/alu_ex_props.sv ====
// Concurrent assertions on the Wishbone arbiter handshakes; attached to wb_arbiter by bind
`timescale 1ns/1ps

module alu_ex_props
    import alu_pkg::*;
(
    input logic    shift_en,
    input logic    reset,
    input logic [1:0] grant,
    input wb_req_t s_req,
    input wb_rsp_t s_rsp,
    input wb_rsp_t m0_rsp,
    input wb_rsp_t m1_rsp
);

    // Slave ack only inside an open cycle
    ack_in_cycle: assert property (@(posedge shift_en) disable iff (reset)
        s_rsp.ack |-> (s_req.cyc && s_req.stb))
        else $error("ack seen without cyc and stb");

    one_grant: assert property (@(posedge shift_en) disable iff (reset) $onehot0(grant))
        else $error("more than one grant");

    // Owner keeps the bus until it closes the cycle
    grant_held: assert property (@(posedge shift_en) disable iff (reset)
        s_req.cyc |=> $stable(grant))
        else $error("grant moved during a bus cycle");

    reset_state: assert property (@(posedge shift_en)
        $past(reset) |-> (grant == 2'b00 && !m0_rsp.ack && !m1_rsp.ack))
        else $error("arbiter not idle after reset");

endmodule

bind wb_arbiter alu_ex_props u_props (
    .shift_en  (shift_en),
    .reset     (reset),
    .grant     (grant),
    .s_req     (s_req),
    .s_rsp     (s_rsp),
    .m0_rsp    (m0_rsp),
    .m1_rsp    (m1_rsp)
);

// ==== verification/alu_ex_checker.sv ====
// Reference model of registers, ALU and memory; compares every retire record and host read
`timescale 1ns/1ps

module alu_ex_checker
    import alu_pkg::*;
(
    input logic    shift_en,
    input logic    reset,
    input instr_t  instr,
    input logic    instr_valid,
    input logic    instr_ready,
    input retire_t retire,
    input wb_req_t host_req,
    input wb_rsp_t host_rsp
);

    typedef struct packed {
        retire_t     rec;
        logic        timed;     // ALU op, must retire one edge later
        logic [31:0] cycle;
    } expect_t;

    string             test_name = "reset";
    int                checks = 0;
    int                errors = 0;
    int                pending = 0;
    logic [31:0]       cycle = 0;
    logic [DATA_W-1:0] m_regs [NUM_REGS];
    logic              m_carry;
    logic [DATA_W-1:0] m_mem [MEM_DEPTH];
    expect_t           exp_q [$];

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("Error: test %s, %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    // Applies one instruction to the model and returns its retire record
    function automatic retire_t predict(input instr_t i);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W:0]   sum;
        retire_t           r;
        a = m_regs[i.rd];
        b = m_regs[i.rs];
        r = '0;
        r.valid  = 1'b1;
        r.opcode = i.opcode;
        r.rd     = i.rd;
        case (i.opcode)
            OP_ADD, OP_ADC:
            begin
                sum = {1'b0, a} + {1'b0, b} + ((i.opcode == OP_ADC) ? {8'd0, m_carry} : 9'd0);
                r.value      = sum[DATA_W-1:0];
                r.flags.cout = sum[DATA_W];
            end
            OP_SUB, OP_CMP:
            begin
                r.value      = a - b;
                r.flags.cout = (a >= b);   // No borrow
                if (i.opcode == OP_CMP)
                begin
                    r.flags.eq = (a == b);
                    r.flags.gt = (a > b);
                    r.flags.lt = (a < b);
                end
            end
            OP_AND:  r.value = a & b;
            OP_OR:   r.value = a | b;
            OP_LAND: r.value = {{(DATA_W-1){1'b0}}, (a != 0) && (b != 0)};
            OP_LOR:  r.value = {{(DATA_W-1){1'b0}}, (a != 0) || (b != 0)};
            OP_LNOT: r.value = {{(DATA_W-1){1'b0}}, (a == 0)};
            OP_SHL:
            begin
                r.value      = {a[DATA_W-2:0], 1'b0};
                r.flags.cout = a[DATA_W-1];
            end
            OP_LDI:  r.value = i.imm;
            OP_LD:   r.value = m_mem[i.imm];
            OP_ST:
            begin
                r.value       = b;
                m_mem[i.imm]  = b;
            end
            default: r.value = '0;
        endcase
        if (i.opcode != OP_CMP && i.opcode != OP_ST)
            m_regs[i.rd] = r.value;
        if (!(i.opcode inside {OP_LDI, OP_LD, OP_ST}))
            m_carry = r.flags.cout;
        return r;
    endfunction

    always @(posedge shift_en)
    begin
        expect_t e;
        cycle = cycle + 1;
        if (reset)
        begin
            exp_q.delete();
            m_carry = 1'b0;
            for (int i = 0; i < NUM_REGS; i++)
                m_regs[i] = '0;
        end
        else
        begin
            if (retire.valid)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("Test %s: a retire record appeared with no instruction accepted",
                             test_name);
                end
                else
                begin
                    e = exp_q.pop_front();
                    check_val("retire opcode", e.rec.opcode, retire.opcode);
                    check_val("retire rd", e.rec.rd, retire.rd);
                    check_val("retire value", e.rec.value, retire.value);
                    check_val("retire flags", e.rec.flags, retire.flags);
                    if (e.timed)
                        check_val("retire latency", 2, cycle - e.cycle);   // Seen one edge late
                end
            end
            if (instr_valid && instr_ready)
            begin
                e.rec   = predict(instr);
                e.timed = !(instr.opcode inside {OP_LD, OP_ST});
                e.cycle = cycle;
                exp_q.push_back(e);
            end
            if (host_rsp.ack)
            begin
                if (host_req.we)
                    m_mem[host_req.adr] = host_req.dat;
                else
                    check_val("host read data", m_mem[host_req.adr], host_rsp.dat);
            end
        end
        pending = exp_q.size();
    end

endmodule

// ==== verification/tb_alu_ex.sv ====
// Testbench top: clock, reset, random instruction and host traffic; the checker does the comparing
`timescale 1ns/1ps

module tb_alu_ex
    import alu_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic        shift_en = 1'b0;
    logic        reset = 1'b1;
    instr_t      instr = '0;
    logic        instr_valid = 1'b0;
    logic        instr_ready;
    wb_req_t     host_req = '0;
    wb_rsp_t     host_rsp;
    retire_t     retire;
    logic [31:0] rng = 32'd80;
    logic [7:0]  st_addrs [$];    // Lower-half addresses already stored
    logic        stored [128];
    int          err_mark;
    int          chk_mark;

    alu_ex_top UUT (
        .shift_en    (shift_en),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .host_req    (host_req),
        .host_rsp    (host_rsp),
        .retire      (retire)
    );

    alu_ex_checker u_chk (.*);

    always #5 shift_en = ~shift_en;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic abort(input string why);
        $display("Timeout: %s", why);
        $display("TB FAILED");
        $finish;
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input opcode_e op, input logic [1:0] rd, input logic [1:0] rs,
                         input logic [7:0] imm);
        int t;
        t = 0;
        instr       = '{opcode: op, rd: rd, rs: rs, imm: imm};
        instr_valid = 1'b1;
        while (!instr_ready && t < WAIT_LIMIT)
        begin
            @(negedge shift_en);
            t++;
        end
        if (!instr_ready)
            abort("instruction was never accepted");
        else
        begin
            @(negedge shift_en);
            instr_valid = 1'b0;
        end
    endtask

    task automatic host_access(input logic we, input logic [7:0] adr, input logic [7:0] dat);
        int t;
        t = 0;
        host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge shift_en);
        while (!host_rsp.ack && t < WAIT_LIMIT)
        begin
            @(negedge shift_en);
            t++;
        end
        if (!host_rsp.ack)
            abort("host access was never acknowledged");
        else
        begin
            @(negedge shift_en);   // Request held through the edge that samples ack
            host_req = '0;
            @(negedge shift_en);   // Idle cycle lets the arbiter move on
        end
    endtask

    task automatic seed_regs();
        logic [31:0] r;
        for (int i = 0; i < NUM_REGS; i++)
        begin
            r = next_rand();
            issue(OP_LDI, i[1:0], 2'd0, r[7:0]);
        end
    endtask

    task automatic mem_op(input logic force_st);
        logic [31:0] r;
        logic [7:0]  a;
        r = next_rand();
        if (force_st || r[8] || st_addrs.size() == 0)
        begin
            a = {1'b0, r[6:0]};
            if (!stored[a[6:0]])
                st_addrs.push_back(a);
            stored[a[6:0]] = 1'b1;
            issue(OP_ST, r[10:9], r[12:11], a);
        end
        else
        begin
            a = st_addrs[r[20:13] % st_addrs.size()];
            issue(OP_LD, r[10:9], r[12:11], a);
        end
    endtask

    task automatic host_traffic(input int n);
        logic [31:0] r;
        logic [7:0]  a;
        for (int i = 0; i < n; i++)
        begin
            r = next_rand();
            a = {1'b1, r[6:0]};
            host_access(1'b1, a, r[15:8]);
            host_access(1'b0, a, 8'h00);
        end
    endtask

    task automatic start_test(input string name);
        u_chk.test_name = name;
        err_mark = u_chk.errors;
        chk_mark = u_chk.checks;
    endtask

    task automatic wait_retired();
        int t;
        t = 0;
        while (u_chk.pending != 0 && t < WAIT_LIMIT)
        begin
            @(negedge shift_en);
            t++;
        end
        if (u_chk.pending != 0)
            abort("instructions did not retire");
        else
            repeat (2) @(negedge shift_en);
    endtask

    task automatic end_test();
        wait_retired();
        $display("Test %s: %0d checks, %0d errors", u_chk.test_name,
                 u_chk.checks - chk_mark, u_chk.errors - err_mark);
    endtask

    initial
    begin
        logic [31:0] r;
        opcode_e     arith_ops [4] = '{OP_ADD, OP_ADC, OP_SUB, OP_SHL};
        opcode_e     logic_ops [5] = '{OP_AND, OP_OR, OP_LAND, OP_LOR, OP_LNOT};
        for (int i = 0; i < 128; i++)
            stored[i] = 1'b0;
        repeat (10) @(posedge shift_en);
        @(negedge shift_en);
        reset = 1'b0;

        start_test("reset");
        repeat (3) @(negedge shift_en);   // No retire may show up here
        u_chk.check_val("instr_ready", 1, instr_ready);
        end_test();

        start_test("arith");
        seed_regs();
        for (int i = 0; i < 200; i++)
        begin
            r = next_rand();
            issue(arith_ops[r[1:0]], r[3:2], r[5:4], 8'h00);
        end
        end_test();

        start_test("logic");
        seed_regs();
        for (int i = 0; i < 100; i++)
        begin
            r = next_rand();
            issue(logic_ops[r % 5], r[4:3], r[6:5], 8'h00);
            if (r[12:9] == 4'd0)
                issue(OP_LDI, r[4:3], 2'd0, 8'h00);   // Zero operands for the logical forms
        end
        end_test();

        start_test("compare");
        seed_regs();
        for (int i = 0; i < 60; i++)
        begin
            r = next_rand();
            issue(OP_CMP, r[1:0], r[3:2], 8'h00);
        end
        for (int i = 0; i < 20; i++)
        begin
            r = next_rand();
            issue(OP_LDI, 2'd1, 2'd0, r[7:0]);
            issue(OP_LDI, 2'd2, 2'd0, r[7:0]);
            issue(OP_CMP, 2'd1, 2'd2, 8'h00);
            issue(OP_CMP, r[9:8], r[9:8], 8'h00);
        end
        end_test();

        start_test("memory");
        seed_regs();
        for (int i = 0; i < 40; i++)
        begin
            mem_op(1'b1);
            mem_op(1'b0);
        end
        wait_retired();
        foreach (st_addrs[i])
            host_access(1'b0, st_addrs[i], 8'h00);
        end_test();

        start_test("arbitration");
        fork
            for (int i = 0; i < 60; i++)
                mem_op(1'b0);
            host_traffic(40);
        join
        end_test();

        $display("Totals: %0d checks, %0d errors", u_chk.checks, u_chk.errors);
        if (u_chk.errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== alu_ex_top.f ====
rtl/alu_pkg.sv
rtl/pl_alu.sv
rtl/ex_stage.sv
rtl/wb_arbiter.sv
rtl/data_mem.sv
rtl/alu_ex_top.sv
verification/alu_ex_props.sv
verification/alu_ex_checker.sv
verification/tb_alu_ex.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_alu_ex -f alu_ex_top.f -o sim_alu_ex

out=$(./obj_dir/sim_alu_ex)
echo "$out"

if grep -qx "TB PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi
